// File: include/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Width of data words, instruction words and the PC
`define CPU_DATA_WIDTH 16

// Unified instruction and data memory
`define CPU_MEM_DEPTH 256
`define CPU_MEM_ADDR_WIDTH 8

// Size of the general purpose register file
`define CPU_REG_COUNT 4

`endif

// File: project.f
+incdir+include
src/cpuPkg.sv
src/memory.sv
src/registerFile.sv
src/ALU.sv
src/decoder.sv
src/processor.sv
sim/clockGen.sv
sim/processorTb.sv

// File: run.sh
#!/bin/sh
# Builds the processor testbench with Verilator and runs it.
# The exit status is the simulator's, so a $fatal gives a failing status.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -j 0 --top-module processorTb -f project.f -o processorSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build returned status $status"
  exit "$status"
fi

./obj_dir/processorSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulator returned status $status"
  exit "$status"
fi

exit 0

// File: sim/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic clk
);

  // 40 ns period, first rising edge at 20 ns
  localparam int halfPeriod = 20;

  initial begin
    clk = 1'b0;
    forever begin
      #halfPeriod clk = ~clk;
    end
  end

endmodule

// File: sim/processorTb.sv
`timescale 1ns/10ps

module processorTb;
  import cpuPkg::*;

  localparam string vectorFile = "sim/processor_vectors.txt";

  logic       clk;
  logic       rst;
  logic       run;
  logic       progWe;
  memAddr_t   progAddr;
  word_t      progData;
  logic [7:0] led;

  // Program image and expected led trace, filled from the vectors file
  memAddr_t   loadAddr [$];
  word_t      loadWord [$];
  word_t      expLed [$];

  // Timeout bookkeeping
  int         cycleCount;
  int         cycleLimit;

  clockGen clkGen (
    .clk(clk)
  );

  processor DUT (
    .clk(clk),
    .rst(rst),
    .run(run),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData),
    .led(led)
  );

  // Compares one value and stops the run on a mismatch
  task automatic check(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Wrong value in %s", name);
    end
  endtask

  // Ends the run for anything that is not a wrong value
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "Run aborted");
  endtask

  // Drops the rest of a comment line
  task automatic skipLine(input int fd);
    int c;

    c = $fgetc(fd);
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  // P lines go to the load queues, E lines to the expected trace
  task automatic readVectors();
    int         fd;
    int         code;
    logic [7:0] tag;
    memAddr_t   addr;
    word_t      value;
    bit         atEnd;

    fd = $fopen(vectorFile, "r");
    if (fd == 0) begin
      abortRun("Cannot open the vectors file sim/processor_vectors.txt");
    end else begin
      atEnd = 1'b0;
      while (!atEnd) begin
        code = $fscanf(fd, " %c", tag);
        if (code != 1) begin
          atEnd = 1'b1;
        end else begin
          case (tag)
            "#": skipLine(fd);
            "P": begin
              code = $fscanf(fd, "%h %h", addr, value);
              if (code != 2) begin
                abortRun("A P line in the vectors file has no address and word");
              end else begin
                loadAddr.push_back(addr);
                loadWord.push_back(value);
              end
            end
            "E": begin
              code = $fscanf(fd, "%h", value);
              if (code != 1) begin
                abortRun("An E line in the vectors file has no led value");
              end else begin
                expLed.push_back(value);
              end
            end
            default: abortRun($sformatf("Unknown line tag %c in the vectors file", tag));
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // Fills memory while the core is held, led must stay at 0
  task automatic loadProgram();
    int i;

    for (i = 0; i < loadAddr.size(); i++) begin
      @(negedge clk);
      check("reset and load hold", 16'h0000, {8'h00, led});
      progWe   = 1'b1;
      progAddr = loadAddr[i];
      progData = loadWord[i];
    end
    @(negedge clk);
    check("reset and load hold", 16'h0000, {8'h00, led});
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    run      = 1'b1;
  endtask

  // One instruction per rising edge, led checked at the falling edge after it
  task automatic runProgram();
    int i;

    for (i = 0; i < expLed.size(); i++) begin
      @(negedge clk);
      check($sformatf("run cycle %0d", i + 1), expLed[i], {8'h00, led});
    end
  endtask

  // Cycle counter against a limit taken from the vectors file
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the test did not end within %0d cycles", cycleLimit);
      $display("Simulation failed");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    rst      = 1'b1;
    run      = 1'b0;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;

    readVectors();
    cycleLimit = (loadAddr.size() + expLed.size() + 3) * 2 + 20;

    // Reset held for three rising edges
    repeat (3) @(negedge clk);
    rst = 1'b0;

    loadProgram();
    runProgram();

    if (expLed.size() == 0) begin
      abortRun("The vectors file holds no expected led values");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

// File: sim/processor_vectors.txt
# P <addr> <word>  memory word written before run goes high, both in hex
# E <led>          expected led after each running cycle, in hex, in order
#
# Constants
P 80 0005
P 81 0003
P 82 ffff
P 83 0001
P 84 fffe
P 85 0090
P 86 0020
P 87 0000
P 90 dead  # overwritten by the indirect store
#
# Sequential fetch, LDA, ADD and a BZ that falls through
P 00 4480  # lda r1, [80] -> 0005
P 01 4881  # lda r2, [81] -> 0003
P 02 0d80  # add r3, r1, r2 -> 0008, z = 0
P 03 6004  # bz +4, not taken
P 04 4482  # lda r1, [82] -> ffff
P 05 1940  # nand r2, r1, r1 -> 0000, z = 1
P 06 6003  # bz +3, taken to 09
P 07 f000  # skipped
P 08 f000  # skipped
#
# Counted loop closed by a backward BR, body runs twice
P 09 4883  # lda r2, [83] -> 0001
P 0a 4c84  # lda r3, [84] -> fffe
P 0b 0f80  # add r3, r3, r2
P 0c 6002  # bz +2, leaves once r3 reaches 0
P 0d 70fe  # br -2
#
# Indirect store and load through r1, then JR on the loaded value
P 0e 4485  # lda r1, [85] -> 0090
P 0f 4886  # lda r2, [86] -> 0020
P 10 3180  # st [r1], r2
P 11 2d00  # ld r3, [r1] -> 0020
P 12 8300  # jr r3
#
# Zero flag held across loads, stores and branches
P 20 02c0  # add r0, r2, r3 -> 0040, z = 0
P 21 4c87  # lda r3, [87] -> 0000
P 22 31c0  # st [r1], r3
P 23 2900  # ld r2, [r1] -> 0000
P 24 7001  # br +1
P 25 6005  # bz +5, not taken
P 26 4082  # lda r0, [82] -> ffff
P 27 1c00  # nand r3, r0, r0 -> 0000, z = 1
P 28 5088  # sta [88], r2
P 29 4880  # lda r2, [80] -> 0005
P 2a 6006  # bz +6, taken to 30
P 30 7000  # br 0, core parks here
#
# Expected led trace
E 01
E 02
E 03
E 04  # bz falls through
E 05
E 06
E 09  # bz taken after nand
E 0a
E 0b
E 0c  # loop pass one
E 0d
E 0b  # br back
E 0c  # loop pass two
E 0e  # bz leaves the loop
E 0f
E 10
E 11
E 12
E 20  # jr to the stored value
E 21
E 22
E 23
E 24
E 25
E 26  # bz held at z = 0
E 27
E 28
E 29
E 2a
E 30  # bz held at z = 1
E 30
E 30

// File: src/ALU.sv
`timescale 1ns/10ps

module ALU (
  input  logic           clk,
  input  logic           rst,
  input  cpuPkg::word_t  in1,
  input  cpuPkg::word_t  in2,
  input  cpuPkg::aluOp_t op,
  input  logic           en,
  output cpuPkg::word_t  out,
  output logic           zFlag
);
  import cpuPkg::*;

  // Result is purely combinational
  always_comb begin
    case (op)
      ALU_NAND: out = ~(in1 & in2);
      default:  out = in1 + in2;
    endcase
  end

  // Zero flag only moves on an ADD or NAND, held otherwise
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      zFlag <= 1'b0;
    end else if (en) begin
      zFlag <= (out == '0);
    end
  end

endmodule

// File: src/cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

  // Data, instruction and PC value
  typedef logic [`CPU_DATA_WIDTH-1:0] word_t;

  // Register index
  typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIdx_t;

  // Word index into memory
  typedef logic [`CPU_MEM_ADDR_WIDTH-1:0] memAddr_t;

  // Opcode field, instruction bits 15:12
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    NAND = 4'd1,
    LD   = 4'd2,
    ST   = 4'd3,
    LDA  = 4'd4,
    STA  = 4'd5,
    BZ   = 4'd6,
    BR   = 4'd7,
    JR   = 4'd8
  } opcode_t;

  // Next PC source
  typedef enum logic [1:0] {
    PC_INC,
    PC_REL,
    PC_REG
  } pcSel_t;

  // ALU function
  typedef enum logic {
    ALU_ADD,
    ALU_NAND
  } aluOp_t;

endpackage

// File: src/decoder.sv
`timescale 1ns/10ps

module decoder (
  input  cpuPkg::word_t   instruction,
  input  logic            zFlag,
  output cpuPkg::pcSel_t  nextPCSel,
  output logic            regInSource,
  output logic            regInEn,
  output cpuPkg::regIdx_t regInSel,
  output cpuPkg::regIdx_t regOutSel1,
  output cpuPkg::regIdx_t regOutSel2,
  output cpuPkg::aluOp_t  aluOp,
  output logic            aluEn,
  output logic            dWE,
  output logic            dAddrSel,
  output cpuPkg::word_t   imm
);
  import cpuPkg::*;

  opcode_t opcode;
  word_t   immZero;
  word_t   immSign;

  assign opcode = opcode_t'(instruction[15:12]);

  // Register fields sit at fixed positions
  assign regInSel   = instruction[11:10];
  assign regOutSel1 = instruction[9:8];
  assign regOutSel2 = instruction[7:6];

  // Absolute addresses are zero-extended, branch offsets sign-extended
  assign immZero = {8'b0, instruction[7:0]};
  assign immSign = {{8{instruction[7]}}, instruction[7:0]};

  always_comb begin
    // Unknown opcodes fall through as a no-op
    nextPCSel   = PC_INC;
    regInSource = 1'b0;
    regInEn     = 1'b0;
    aluOp       = ALU_ADD;
    aluEn       = 1'b0;
    dWE         = 1'b0;
    dAddrSel    = 1'b0;
    imm         = immZero;

    case (opcode)
      ADD: begin
        regInEn = 1'b1;
        aluEn   = 1'b1;
      end
      NAND: begin
        regInEn = 1'b1;
        aluOp   = ALU_NAND;
        aluEn   = 1'b1;
      end
      LD: begin
        regInSource = 1'b1;
        regInEn     = 1'b1;
        dAddrSel    = 1'b1;
      end
      LDA: begin
        regInSource = 1'b1;
        regInEn     = 1'b1;
      end
      ST: begin
        dWE      = 1'b1;
        dAddrSel = 1'b1;
      end
      STA: begin
        dWE = 1'b1;
      end
      BZ: begin
        imm       = immSign;
        nextPCSel = zFlag ? PC_REL : PC_INC;
      end
      BR: begin
        imm       = immSign;
        nextPCSel = PC_REL;
      end
      // Target comes from rs1
      JR: nextPCSel = PC_REG;
      default: ;
    endcase
  end

endmodule

// File: src/memory.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module memory (
  input  logic             clk,
  input  cpuPkg::memAddr_t iAddr,
  output cpuPkg::word_t    iDataOut,
  input  cpuPkg::memAddr_t dAddr,
  input  logic             dWE,
  input  cpuPkg::word_t    dDataIn,
  output cpuPkg::word_t    dDataOut,
  input  logic             progWe,
  input  cpuPkg::memAddr_t progAddr,
  input  cpuPkg::word_t    progData
);
  import cpuPkg::*;

  word_t    mem [`CPU_MEM_DEPTH];

  logic     wrEn;
  memAddr_t wrAddr;
  word_t    wrData;

  // Program loading takes the single write port when active
  assign wrEn   = progWe | dWE;
  assign wrAddr = progWe ? progAddr : dAddr;
  assign wrData = progWe ? progData : dDataIn;

  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Both read ports are combinational
  assign iDataOut = mem[iAddr];
  assign dDataOut = mem[dAddr];

endmodule

// File: src/processor.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module processor (
  input  logic             clk,
  input  logic             rst,
  input  logic             run,
  input  logic             progWe,
  input  cpuPkg::memAddr_t progAddr,
  input  cpuPkg::word_t    progData,
  output logic [7:0]       led
);
  import cpuPkg::*;

  word_t    pc;
  word_t    nextPC;
  word_t    instruction;

  pcSel_t   nextPCSel;
  logic     regInSource;
  logic     regInEn;
  regIdx_t  regInSel;
  regIdx_t  regOutSel1;
  regIdx_t  regOutSel2;
  aluOp_t   aluOp;
  logic     aluEn;
  logic     dWE;
  logic     dAddrSel;
  word_t    imm;

  word_t    regIn;
  word_t    regOut1;
  word_t    regOut2;
  word_t    aluOut;
  logic     zFlag;
  memAddr_t dAddr;
  word_t    dDataOut;

  memory mem (
    .clk(clk), .iAddr(pc[`CPU_MEM_ADDR_WIDTH-1:0]), .iDataOut(instruction),
    .dAddr(dAddr), .dWE(dWE & run), .dDataIn(regOut2), .dDataOut(dDataOut),
    .progWe(progWe), .progAddr(progAddr), .progData(progData)
  );

  registerFile regFile (
    .clk(clk), .rst(rst), .in(regIn), .inSel(regInSel), .inEn(regInEn & run),
    .outSel1(regOutSel1), .outSel2(regOutSel2), .out1(regOut1), .out2(regOut2)
  );

  ALU alu (
    .clk(clk), .rst(rst), .in1(regOut1), .in2(regOut2), .op(aluOp),
    .en(aluEn & run), .out(aluOut), .zFlag(zFlag)
  );

  decoder decode (
    .instruction(instruction), .zFlag(zFlag), .nextPCSel(nextPCSel),
    .regInSource(regInSource), .regInEn(regInEn), .regInSel(regInSel),
    .regOutSel1(regOutSel1), .regOutSel2(regOutSel2), .aluOp(aluOp),
    .aluEn(aluEn), .dWE(dWE), .dAddrSel(dAddrSel), .imm(imm)
  );

  // Next PC selection
  always_comb begin
    case (nextPCSel)
      PC_REL:  nextPC = pc + imm;
      PC_REG:  nextPC = regOut1;
      default: nextPC = pc + 16'd1;
    endcase
  end

  // PC holds while the core is stopped for loading
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (run) begin
      pc <= nextPC;
    end
  end

  // Write-back and data address muxes
  assign regIn = regInSource ? dDataOut : aluOut;
  assign dAddr = dAddrSel ? regOut1[`CPU_MEM_ADDR_WIDTH-1:0]
                          : imm[`CPU_MEM_ADDR_WIDTH-1:0];

  assign led = pc[7:0];

endmodule

// File: src/registerFile.sv
`timescale 1ns/10ps
`include "cpu_defines.svh"

module registerFile (
  input  logic            clk,
  input  logic            rst,
  input  cpuPkg::word_t   in,
  input  cpuPkg::regIdx_t inSel,
  input  logic            inEn,
  input  cpuPkg::regIdx_t outSel1,
  input  cpuPkg::regIdx_t outSel2,
  output cpuPkg::word_t   out1,
  output cpuPkg::word_t   out2
);
  import cpuPkg::*;

  word_t regs [`CPU_REG_COUNT];

  // All registers start at zero
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (inEn) begin
      regs[inSel] <= in;
    end
  end

  // Read ports see a write from the previous edge
  assign out1 = regs[outSel1];
  assign out2 = regs[outSel2];

endmodule
